//--- verilog.f
queuePkg.sv
scanTimer.sv
keyScanner.sv
ticketCounter.sv
displayDriver.sv
queuePanel.sv
keypadModel.sv
tbQueuePanel.sv

//--- tbQueuePanel.sv
/* Queue panel testbench with the key table, display reader,
   value check and watchdog */
`timescale 1ns/1ps
`default_nettype none

module tbQueuePanel;

  logic          Clk10M;
  logic          Clr;
  queuePkg::colT Co;
  queuePkg::selT De;
  queuePkg::segT Seg;
  logic          KeyHeld;

  queuePkg::selT keyRow;
  queuePkg::colT keyMask;
  logic          keyPress;

  // Key table with one press per entry
  string         testName [0:31];
  queuePkg::selT testRow  [0:31];
  queuePkg::colT testMask [0:31];
  int            testHold [0:31];   // Scan rotations
  queuePkg::bcdT testExp  [0:31];
  int            numTests;

  queuePanel dut_i (
    .Clk10M  (Clk10M),
    .Clr     (Clr),
    .Co      (Co),
    .De      (De),
    .Seg     (Seg),
    .KeyHeld (KeyHeld)
  );

  keypadModel keypad_i (
    .De      (De),
    .row     (keyRow),
    .colMask (keyMask),
    .press   (keyPress),
    .Co      (Co)
  );

  initial
  begin
    Clk10M = 1'b0;
    forever #50 Clk10M = ~Clk10M;     // 10 MHz
  end

  task automatic checkValue(string name, logic [11:0] expected, logic [11:0] actual);
    if (expected !== actual)
    begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Segment pattern back to a digit
  function automatic queuePkg::digitT segToDigit(queuePkg::segT seg);
    queuePkg::digitT d;
    d = 4'hE;                          // Pattern outside the table
    if (seg == queuePkg::SegBlank)
      d = queuePkg::DigitBlank;
    for (int i = 0; i < 10; i++)
      if (seg == queuePkg::SegDigit[i])
        d = queuePkg::digitT'(i);
    return d;
  endfunction

  // One full select rotation sampled mid-cycle
  task automatic readDisplay(output queuePkg::bcdT shown);
    queuePkg::digitT hund;
    queuePkg::digitT tens;
    queuePkg::digitT units;
    hund  = 4'hD;                      // Never enabled
    tens  = 4'hD;
    units = 4'hD;
    repeat (8 * queuePkg::ScanPrescale)
    begin
      @(negedge Clk10M);
      case (De)
        queuePkg::SelHundreds: hund  = segToDigit(Seg);
        queuePkg::SelTens:     tens  = segToDigit(Seg);
        queuePkg::SelUnits:    units = segToDigit(Seg);
        default:               ;
      endcase
    end
    shown = {hund, tens, units};
  endtask

  task automatic addEntry(string name, queuePkg::selT row, queuePkg::colT mask,
                          queuePkg::bcdT expected);
    testName[numTests] = name;
    testRow[numTests]  = row;
    testMask[numTests] = mask;
    testHold[numTests] = $urandom % 3 + 1;
    testExp[numTests]  = expected;
    numTests++;
  endtask

  task automatic loadTable();
    numTests = 0;
    addEntry("digit 1",       3'd0, 3'b100, 12'h001);
    addEntry("digit 2",       3'd0, 3'b010, 12'h012);
    addEntry("digit 3",       3'd0, 3'b001, 12'h123);
    addEntry("digit 4",       3'd1, 3'b100, 12'h234);
    addEntry("hash 234",      3'd3, 3'b001, 12'h235);
    addEntry("digit 2 again", 3'd0, 3'b010, 12'h352);
    addEntry("digit 3 again", 3'd0, 3'b001, 12'h523);
    addEntry("digit 9",       3'd2, 3'b001, 12'h239);
    addEntry("hash 239",      3'd3, 3'b001, 12'h240);
    addEntry("star 240",      3'd3, 3'b100, 12'h239);
    addEntry("digit 2 third", 3'd0, 3'b010, 12'h392);
    addEntry("digit 9 tens",  3'd2, 3'b001, 12'h929);
    addEntry("digit 9 units", 3'd2, 3'b001, 12'h299);
    addEntry("hash 299",      3'd3, 3'b001, 12'h300);
    addEntry("star 300",      3'd3, 3'b100, 12'h299);
    addEntry("digit 9 fill",  3'd2, 3'b001, 12'h999);
    addEntry("hash 999",      3'd3, 3'b001, 12'h000);
    addEntry("star 000",      3'd3, 3'b100, 12'h999);
    addEntry("two columns",   3'd0, 3'b110, 12'h99F);   // Units digit blank
  endtask

  // Longest hold is 3 rotations and 4 more cover press, release and readout
  initial
  begin
    time limit;
    #1;
    limit = numTests * (3 + 4) * 8 * queuePkg::ScanPrescale * 100;
    #(limit);
    $display("Watchdog expired before all keys were handled");
    $display("TB FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial
  begin
    int            seed;
    queuePkg::bcdT shown;
    Clr      = 1'b1;
    keyPress = 1'b0;
    keyRow   = '0;
    keyMask  = '0;
    seed     = $urandom(32'h2524);
    loadTable();
    repeat (16) @(posedge Clk10M);
    #10 Clr = 1'b0;

    readDisplay(shown);
    checkValue("reset display", 12'h000, shown);
    checkValue("reset KeyHeld", 12'h000, {11'd0, KeyHeld});

    for (int t = 0; t < numTests; t++)
    begin
      @(posedge Clk10M);
      #10;
      keyRow   = testRow[t];
      keyMask  = testMask[t];
      keyPress = 1'b1;
      while (KeyHeld !== 1'b1)
        @(negedge Clk10M);
      // Lock must stay set for the whole hold
      repeat (testHold[t] * 8 * queuePkg::ScanPrescale)
      begin
        @(negedge Clk10M);
        checkValue({testName[t], " KeyHeld"}, 12'h001, {11'd0, KeyHeld});
      end
      @(posedge Clk10M);
      #10 keyPress = 1'b0;
      while (KeyHeld !== 1'b0)
        @(negedge Clk10M);
      @(posedge Clk10M);              // Number updates here
      readDisplay(shown);
      checkValue(testName[t], testExp[t], shown);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- keypadModel.sv
/* Testbench keypad, pulls the pressed columns low while their row is selected */
`timescale 1ns/1ps
`default_nettype none

module keypadModel (
  input  queuePkg::selT De,
  input  queuePkg::selT row,
  input  queuePkg::colT colMask,    // Active high, bit 2 is the left column
  input  logic          press,
  output queuePkg::colT Co
);

  // Columns float high unless the pressed row is driven
  assign Co = (press && De == row) ? ~colMask : queuePkg::ColIdle;

endmodule

`default_nettype wire

//--- queuePanel.sv
/* Queue-number panel top level, scan timer, key scanner,
   ticket counter and display driver */
`timescale 1ns/1ps
`default_nettype none

module queuePanel (
  input  logic          Clk10M,
  input  logic          Clr,
  input  queuePkg::colT Co,
  output queuePkg::selT De,
  output queuePkg::segT Seg,
  output logic          KeyHeld
);

  queuePkg::scanT     scan;
  queuePkg::keyEventT keyEvent;
  queuePkg::bcdT      number;

  scanTimer scanTimer_i (
    .Clk10M (Clk10M),
    .Clr    (Clr),
    .scan   (scan)
  );

  keyScanner keyScanner_i (
    .Clk10M   (Clk10M),
    .Clr      (Clr),
    .scan     (scan),
    .Co       (Co),
    .keyEvent (keyEvent),
    .KeyHeld  (KeyHeld)
  );

  ticketCounter ticketCounter_i (
    .Clk10M   (Clk10M),
    .Clr      (Clr),
    .keyEvent (keyEvent),
    .number   (number)
  );

  // One select drives keypad rows and digit enables
  assign De = scan.sel;

  displayDriver displayDriver_i (
    .De     (De),
    .number (number),
    .Seg    (Seg)
  );

endmodule

`default_nettype wire

//--- displayDriver.sv
/* Digit multiplexer and seven-segment decoder */
`timescale 1ns/1ps
`default_nettype none

module displayDriver (
  input  queuePkg::selT De,
  input  queuePkg::bcdT number,
  output queuePkg::segT Seg
);

  queuePkg::digitT digit;

  // Pick the digit for the enabled position
  always_comb
  begin
    case (De)
      queuePkg::SelHundreds:
        digit = number[2*queuePkg::DigitW +: queuePkg::DigitW];
      queuePkg::SelTens:
        digit = number[queuePkg::DigitW +: queuePkg::DigitW];
      queuePkg::SelUnits:
        digit = number[0 +: queuePkg::DigitW];
      default:
        digit = queuePkg::DigitBlank;    // Keypad rows 0..2 and selects 6, 7
    endcase
  end

  always_comb
  begin
    if (digit <= 4'd9)
      Seg = queuePkg::SegDigit[digit];
    else
      Seg = queuePkg::SegBlank;          // Illegal code shows dark
  end

endmodule

`default_nettype wire

//--- ticketCounter.sv
/* Three-digit BCD queue number with digit entry,
   up step and down step */
`timescale 1ns/1ps
`default_nettype none

module ticketCounter (
  input  logic               Clk10M,
  input  logic               Clr,
  input  queuePkg::keyEventT keyEvent,
  output queuePkg::bcdT      number
);

  // BCD increment with ripple carry, 999 wraps to 000
  function automatic queuePkg::bcdT stepUp(queuePkg::bcdT n);
    queuePkg::bcdT   r;
    queuePkg::digitT d;
    logic            carry;
    r     = n;
    carry = 1'b1;
    for (int i = 0; i < queuePkg::NumDigits; i++)
    begin
      d = n[i*queuePkg::DigitW +: queuePkg::DigitW];
      if (carry)
      begin
        if (d == 4'd9)
          d = 4'd0;                      // Carry moves on
        else
        begin
          d     = d + 1'b1;
          carry = 1'b0;
        end
      end
      r[i*queuePkg::DigitW +: queuePkg::DigitW] = d;
    end
    return r;
  endfunction

  // BCD decrement with ripple borrow, 000 wraps to 999
  function automatic queuePkg::bcdT stepDown(queuePkg::bcdT n);
    queuePkg::bcdT   r;
    queuePkg::digitT d;
    logic            borrow;
    r      = n;
    borrow = 1'b1;
    for (int i = 0; i < queuePkg::NumDigits; i++)
    begin
      d = n[i*queuePkg::DigitW +: queuePkg::DigitW];
      if (borrow)
      begin
        if (d == 4'd0)
          d = 4'd9;
        else
        begin
          d      = d - 1'b1;
          borrow = 1'b0;
        end
      end
      r[i*queuePkg::DigitW +: queuePkg::DigitW] = d;
    end
    return r;
  endfunction

  function automatic logic allBcd(queuePkg::bcdT n);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < queuePkg::NumDigits; i++)
      if (n[i*queuePkg::DigitW +: queuePkg::DigitW] > 4'd9)
        ok = 1'b0;
    return ok;
  endfunction

  always_ff @(posedge Clk10M or posedge Clr)
  begin
    if (Clr)
      number <= '0;
    else if (keyEvent.valid)
    begin
      case (keyEvent.code)
        queuePkg::KeyHash: number <= stepUp(number);
        queuePkg::KeyStar: number <= stepDown(number);
        default:           number <= {number[2*queuePkg::DigitW-1:0], keyEvent.code};
      endcase
    end
  end

  // A blank digit entered by an illegal key is carried as it stands
  stepKeepsBcd: assert property (
    @(posedge Clk10M) disable iff (Clr)
      (keyEvent.valid && allBcd(number) &&
       (keyEvent.code == queuePkg::KeyHash || keyEvent.code == queuePkg::KeyStar))
      |=> allBcd(number)
  ) else $error("up or down step left a non-BCD digit");

endmodule

`default_nettype wire

//--- keyScanner.sv
/* Keypad sampling, key decode, held-key lock
   and the release event */
`timescale 1ns/1ps
`default_nettype none

module keyScanner (
  input  logic               Clk10M,
  input  logic               Clr,
  input  queuePkg::scanT     scan,
  input  queuePkg::colT      Co,
  output queuePkg::keyEventT keyEvent,
  output logic               KeyHeld
);

  logic              locked;
  logic              relPulse;
  queuePkg::selT     heldRow;
  queuePkg::keyCodeT heldCode;

  // Row and column pattern to key code
  function automatic queuePkg::keyCodeT decodeKey(
    queuePkg::selT row,
    queuePkg::colT col
  );
    queuePkg::keyCodeT code;
    case ({row, col})
      6'b000_011: code = 4'd1;
      6'b000_101: code = 4'd2;
      6'b000_110: code = 4'd3;
      6'b001_011: code = 4'd4;
      6'b001_101: code = 4'd5;
      6'b001_110: code = 4'd6;
      6'b010_011: code = 4'd7;
      6'b010_101: code = 4'd8;
      6'b010_110: code = 4'd9;
      6'b011_011: code = queuePkg::KeyStar;
      6'b011_101: code = 4'd0;
      6'b011_110: code = queuePkg::KeyHash;
      default:    code = queuePkg::KeyNone;   // Two keys in a row and the like
    endcase
    return code;
  endfunction

  always_ff @(posedge Clk10M or posedge Clr)
  begin
    if (Clr)
    begin
      locked   <= 1'b0;
      relPulse <= 1'b0;
      heldRow  <= '0;
      heldCode <= queuePkg::KeyNone;
    end
    else
    begin
      relPulse <= 1'b0;
      if (scan.step)
      begin
        if (!locked && Co != queuePkg::ColIdle)
        begin
          locked   <= 1'b1;                 // New press
          heldRow  <= scan.sel;
          heldCode <= decodeKey(scan.sel, Co);
        end
        else if (locked && Co == queuePkg::ColIdle && scan.sel == heldRow)
        begin
          // Only the stored row can end the press
          locked   <= 1'b0;
          relPulse <= 1'b1;
        end
      end
    end
  end

  assign keyEvent = '{valid: relPulse, code: heldCode};
  assign KeyHeld  = locked;

  releaseAfterLock: assert property (
    @(posedge Clk10M) disable iff (Clr) relPulse |-> $past(locked)
  ) else $error("release strobe without a locked key");

endmodule

`default_nettype wire

//--- scanTimer.sv
/* Scan prescaler and rotating select counter */
`timescale 1ns/1ps
`default_nettype none

module scanTimer (
  input  logic           Clk10M,
  input  logic           Clr,
  output queuePkg::scanT scan
);

  queuePkg::prescaleT preCnt;
  queuePkg::selT      sel;
  logic               step;

  // Strobe on the last count of each period
  assign step = (preCnt == queuePkg::ScanLast);

  always_ff @(posedge Clk10M or posedge Clr)
  begin
    if (Clr)
      preCnt <= '0;
    else if (step)
      preCnt <= '0;
    else
      preCnt <= preCnt + 1'b1;
  end

  // Keypad rows and display digits share this rotation
  always_ff @(posedge Clk10M or posedge Clr)
  begin
    if (Clr)
      sel <= '0;
    else if (step)
      sel <= sel + 1'b1;           // Wraps 7 to 0
  end

  assign scan = '{step: step, sel: sel};

  stepSingle: assert property (@(posedge Clk10M) disable iff (Clr) step |=> !step)
    else $error("scan step strobe high on two consecutive cycles");

endmodule

`default_nettype wire

//--- queuePkg.sv
/* Shared widths, types and structs, key codes, scan prescale
   and the seven-segment pattern table */
`default_nettype none

package queuePkg;

  // Clk10M cycles per scan step, 8192 on the board
  localparam int ScanPrescale = 16;
  localparam int ScanCntW     = $clog2(ScanPrescale);
  localparam int DigitW       = 4;
  localparam int NumDigits    = 3;

  typedef logic [2:0]                  selT;      // Rows 0..3, digits 3..5
  typedef logic [2:0]                  colT;      // Active low, MSB is the left column
  typedef logic [3:0]                  keyCodeT;
  typedef logic [DigitW-1:0]           digitT;
  typedef logic [NumDigits*DigitW-1:0] bcdT;      // Hundreds in the top nibble
  typedef logic [6:0]                  segT;      // a..g, a is bit 6
  typedef logic [ScanCntW-1:0]         prescaleT;

  typedef struct packed {
    logic step;                                   // One cycle per scan step
    selT  sel;
  } scanT;

  typedef struct packed {
    logic    valid;                               // Key released
    keyCodeT code;
  } keyEventT;

  // Digit keys carry their own value
  localparam keyCodeT KeyStar = 4'd10;
  localparam keyCodeT KeyHash = 4'd11;
  localparam keyCodeT KeyNone = 4'd15;

  localparam colT ColIdle = 3'b111;

  // Display digit positions in the select rotation
  localparam selT SelHundreds = 3'd3;
  localparam selT SelTens     = 3'd4;
  localparam selT SelUnits    = 3'd5;

  localparam digitT    DigitBlank = 4'hF;
  localparam prescaleT ScanLast   = prescaleT'(ScanPrescale - 1);

  localparam segT SegBlank = 7'b0000000;

  localparam segT SegDigit [0:9] = '{
    7'b1111110,   // 0
    7'b0110000,   // 1
    7'b1101101,   // 2
    7'b1111001,   // 3
    7'b0110011,   // 4
    7'b1011011,   // 5
    7'b1011111,   // 6
    7'b1110000,   // 7
    7'b1111111,   // 8
    7'b1111011    // 9
  };

endpackage

`default_nettype wire
